// File: hdl/apb_pkg.sv
`default_nettype none

package apb_pkg;

   localparam int APB_ADDR_W = 12;
   localparam int APB_DATA_W = 32;
   localparam int APB_STRB_W = APB_DATA_W / 8;

   typedef logic [APB_ADDR_W-1:0] apb_addr_t;
   typedef logic [APB_DATA_W-1:0] apb_data_t;
   typedef logic [APB_STRB_W-1:0] apb_strb_t;

   // Address map
   localparam int        SLV_SEL_BIT  = 11;  // Clear: regfile, set: GPIO
   localparam int        RF_DEPTH     = 8;   // Word index from paddr[4:2]
   localparam apb_addr_t GPIO_OUT_OFS = 12'h000;
   localparam apb_addr_t GPIO_IN_OFS  = 12'h004;
   localparam apb_data_t GPIO_W       = 32;

   // Byte lanes of new_d replace old_d where strb is set
   function automatic apb_data_t strb_merge(apb_data_t old_d, apb_data_t new_d, apb_strb_t strb);
      apb_data_t res;
      res = old_d;
      for (int b = 0; b < APB_STRB_W; b++) begin
         if (strb[b]) res[8*b +: 8] = new_d[8*b +: 8];
      end
      return res;
   endfunction

endpackage

`default_nettype wire

// File: hdl/apb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface apb_if
   import apb_pkg::*;
();

   apb_addr_t paddr;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_data_t pwdata;
   apb_strb_t pstrb;
   apb_data_t prdata;
   logic      pready;

   // Bridge or decoder side
   modport master (
      output paddr, psel, penable, pwrite, pwdata, pstrb,
      input  prdata, pready
   );

   modport slave (
      input  paddr, psel, penable, pwrite, pwdata, pstrb,
      output prdata, pready
   );

endinterface

`default_nettype wire

// File: hdl/iob2apb.sv
`timescale 1ns/1ps
`default_nettype none

module iob2apb
   import apb_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,

   // Native request side
   input  logic      iob_valid_i,
   input  apb_addr_t iob_addr_i,
   input  apb_data_t iob_wdata_i,
   input  apb_strb_t iob_wstrb_i,
   output logic      iob_ready_o,
   output apb_data_t iob_rdata_o,
   output logic      iob_rvalid_o,

   apb_if.master     apb_m
);

   typedef enum logic [1:0] {
      IDLE,
      SETUP,
      ACCESS
   } state_t;

   state_t    state_q;
   state_t    state_d;
   logic      done;     // Access cycle with pready
   logic      rvalid_q;
   apb_data_t rdata_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (iob_valid_i) state_d = SETUP;
         end
         SETUP: begin
            state_d = ACCESS;
         end
         ACCESS: begin
            if (apb_m.pready) state_d = IDLE;  // Slave may stretch access
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q  <= IDLE;
         rvalid_q <= 1'b0;
      end else begin
         state_q  <= state_d;
         rvalid_q <= done & ~apb_m.pwrite;  // Reads only
      end
   end

   always_ff @(posedge clk_i) begin
      if (done && !apb_m.pwrite) rdata_q <= apb_m.prdata;
   end

   assign done = (state_q == ACCESS) & apb_m.pready;

   // APB outputs, request held by the master
   assign apb_m.psel    = (state_q != IDLE);
   assign apb_m.penable = (state_q == ACCESS);
   assign apb_m.paddr   = iob_addr_i;
   assign apb_m.pwdata  = iob_wdata_i;
   assign apb_m.pstrb   = iob_wstrb_i;
   assign apb_m.pwrite  = |iob_wstrb_i;  // No strobes means read

   assign iob_ready_o  = done;
   assign iob_rdata_o  = rdata_q;
   assign iob_rvalid_o = rvalid_q;

endmodule

`default_nettype wire

// File: hdl/apb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module apb_decoder
   import apb_pkg::*;
(
   apb_if.slave  up_s,
   apb_if.master rf_m,
   apb_if.master gp_m
);

   logic sel_gp;

   assign sel_gp = up_s.paddr[SLV_SEL_BIT];

   // Only psel is steered
   assign rf_m.psel = up_s.psel & ~sel_gp;
   assign gp_m.psel = up_s.psel & sel_gp;

   assign rf_m.paddr   = up_s.paddr;
   assign rf_m.penable = up_s.penable;
   assign rf_m.pwrite  = up_s.pwrite;
   assign rf_m.pwdata  = up_s.pwdata;
   assign rf_m.pstrb   = up_s.pstrb;

   assign gp_m.paddr   = up_s.paddr;
   assign gp_m.penable = up_s.penable;
   assign gp_m.pwrite  = up_s.pwrite;
   assign gp_m.pwdata  = up_s.pwdata;
   assign gp_m.pstrb   = up_s.pstrb;

   // Response back from the selected slave
   always_comb begin
      up_s.prdata = '0;
      up_s.pready = 1'b0;
      if (rf_m.psel) begin
         up_s.prdata = rf_m.prdata;
         up_s.pready = rf_m.pready;
      end else if (gp_m.psel) begin
         up_s.prdata = gp_m.prdata;
         up_s.pready = gp_m.pready;
      end
   end

endmodule

`default_nettype wire

// File: hdl/apb_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module apb_regfile
   import apb_pkg::*;
(
   input  logic clk_i,
   input  logic rst_n_i,
   apb_if.slave apb_s
);

   localparam int IDX_W = $clog2(RF_DEPTH);

   apb_data_t        mem_q [RF_DEPTH];
   logic [IDX_W-1:0] word_idx;
   logic             access;
   logic             wait_q;  // Set after the first access cycle

   assign word_idx = apb_s.paddr[IDX_W+1:2];
   assign access   = apb_s.psel & apb_s.penable;

   // One wait state on every transfer
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wait_q <= 1'b0;
      end else begin
         wait_q <= access & ~wait_q;
      end
   end

   assign apb_s.pready = access & wait_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < RF_DEPTH; i++) begin
            mem_q[i] <= '0;
         end
      end else if (apb_s.pready && apb_s.pwrite) begin
         mem_q[word_idx] <= strb_merge(mem_q[word_idx], apb_s.pwdata, apb_s.pstrb);
      end
   end

   // Data only valid with pready
   assign apb_s.prdata = apb_s.pready ? mem_q[word_idx] : '0;

endmodule

`default_nettype wire

// File: hdl/apb_gpio.sv
`timescale 1ns/1ps
`default_nettype none

module apb_gpio
   import apb_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,
   apb_if.slave      apb_s,
   input  apb_data_t gpio_i,
   output apb_data_t gpio_o
);

   logic [GPIO_W-1:0] out_q;
   logic [GPIO_W-1:0] sync1_q;
   logic [GPIO_W-1:0] sync2_q;  // Readable input value
   logic              access;
   logic              sel_out;
   logic              sel_in;

   assign access  = apb_s.psel & apb_s.penable;
   assign sel_out = (apb_s.paddr[2] == GPIO_OUT_OFS[2]);
   assign sel_in  = (apb_s.paddr[2] == GPIO_IN_OFS[2]);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         out_q   <= '0;
         sync1_q <= '0;
         sync2_q <= '0;
      end else begin
         sync1_q <= gpio_i;
         sync2_q <= sync1_q;
         if (access && apb_s.pwrite && sel_out) begin
            out_q <= strb_merge(out_q, apb_s.pwdata, apb_s.pstrb);
         end
      end
   end

   // No wait states
   assign apb_s.pready = access;
   assign apb_s.prdata = !access ? '0 : (sel_in ? sync2_q : out_q);

   assign gpio_o = out_q;

endmodule

`default_nettype wire

// File: hdl/iob_apb_sys.sv
`timescale 1ns/1ps
`default_nettype none

module iob_apb_sys
   import apb_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,

   input  logic      iob_valid_i,
   input  apb_addr_t iob_addr_i,
   input  apb_data_t iob_wdata_i,
   input  apb_strb_t iob_wstrb_i,
   output logic      iob_ready_o,
   output apb_data_t iob_rdata_o,
   output logic      iob_rvalid_o,

   input  apb_data_t gpio_i,
   output apb_data_t gpio_o
);

   apb_if apb_up ();  // Bridge to decoder
   apb_if apb_rf ();
   apb_if apb_gp ();

   iob2apb bridge_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .iob_valid_i (iob_valid_i),
      .iob_addr_i  (iob_addr_i),
      .iob_wdata_i (iob_wdata_i),
      .iob_wstrb_i (iob_wstrb_i),
      .iob_ready_o (iob_ready_o),
      .iob_rdata_o (iob_rdata_o),
      .iob_rvalid_o(iob_rvalid_o),
      .apb_m       (apb_up.master)
   );

   apb_decoder decoder_i (
      .up_s(apb_up.slave),
      .rf_m(apb_rf.master),
      .gp_m(apb_gp.master)
   );

   apb_regfile regfile_i (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .apb_s  (apb_rf.slave)
   );

   apb_gpio gpio_blk_i (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .apb_s  (apb_gp.slave),
      .gpio_i (gpio_i),
      .gpio_o (gpio_o)
   );

endmodule

`default_nettype wire

// File: bench/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
   output logic clk_o,
   output logic rst_n_o
);

   localparam int HALF_PERIOD = 20;  // 40 ns clock

   initial begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (2) @(negedge clk_o);  // Two rising edges in reset
      rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// File: bench/iob_apb_sys_assert.sv
`timescale 1ns/1ps
`default_nettype none

module iob_apb_sys_assert
   import apb_pkg::*;
(
   input logic      clk_i,
   input logic      rst_n_i,
   input logic      psel_i,
   input logic      penable_i,
   input logic      pwrite_i,
   input apb_addr_t paddr_i,
   input apb_data_t pwdata_i,
   input apb_strb_t pstrb_i,
   input logic      pready_i,
   input logic      iob_ready_i,
   input logic      iob_rvalid_i
);

   int fail_cnt = 0;  // Failed assertions so far

   // Setup phase lasts exactly one cycle
   setup_then_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      psel_i && !penable_i |=> psel_i && penable_i)
      else begin
         fail_cnt++;
         $error("APB setup cycle not followed by an access cycle");
      end

   // Held transfer while the slave stretches access
   stable_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      psel_i && penable_i && !pready_i |=>
         psel_i && penable_i && $stable(paddr_i) && $stable(pwrite_i) &&
         $stable(pwdata_i) && $stable(pstrb_i))
      else begin
         fail_cnt++;
         $error("APB transfer changed while access was waiting");
      end

   rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iob_rvalid_i |-> $past(iob_ready_i && !pwrite_i))
      else begin
         fail_cnt++;
         $error("Read valid without a read completing the cycle before");
      end

endmodule

bind iob2apb iob_apb_sys_assert assert_i (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .psel_i      (apb_m.psel),
   .penable_i   (apb_m.penable),
   .pwrite_i    (apb_m.pwrite),
   .paddr_i     (apb_m.paddr),
   .pwdata_i    (apb_m.pwdata),
   .pstrb_i     (apb_m.pstrb),
   .pready_i    (apb_m.pready),
   .iob_ready_i (iob_ready_o),
   .iob_rvalid_i(iob_rvalid_o)
);

`default_nettype wire

// File: bench/iob_apb_sys_checker.sv
`timescale 1ns/1ps
`default_nettype none

module iob_apb_sys_checker
   import apb_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  logic      iob_valid_i,
   input  apb_addr_t iob_addr_i,
   input  apb_data_t iob_wdata_i,
   input  apb_strb_t iob_wstrb_i,
   input  logic      iob_ready_i,
   input  apb_data_t iob_rdata_i,
   input  logic      iob_rvalid_i,
   input  apb_data_t gpio_i,
   input  apb_data_t gpio_out_i,
   input  logic      end_i,      // Stimulus finished
   input  int        issued_i,   // Requests sent by the stimulus
   output int        err_cnt_o,
   output int        chk_cnt_o
);

   apb_data_t rf_model [RF_DEPTH];
   apb_data_t gpio_model;
   apb_data_t exp_rdata;
   apb_addr_t exp_addr;
   logic      pend = 1'b0;  // Read done, rvalid due next cycle
   logic      valid_q = 1'b0;
   logic      end_seen = 1'b0;
   int        err_cnt = 0;
   int        chk_cnt = 0;
   int        req_cnt = 0;
   int        ready_cnt = 0;
   int        read_cnt = 0;
   int        rvalid_cnt = 0;

   function automatic apb_data_t merge_bytes(apb_data_t old_d, apb_data_t new_d, apb_strb_t s);
      apb_data_t mask;
      mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
      return (old_d & ~mask) | (new_d & mask);
   endfunction

   // Expected read value for an address
   function automatic apb_data_t ref_read(apb_addr_t addr);
      if (!addr[SLV_SEL_BIT]) return rf_model[addr[4:2]];
      if (addr[2] == GPIO_IN_OFS[2]) return gpio_i;
      return gpio_model;
   endfunction

   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < RF_DEPTH; i++) rf_model[i] = '0;
         gpio_model = '0;
         pend       = 1'b0;
         valid_q    = 1'b0;
      end else begin
         chk_cnt++;
         if (gpio_out_i !== gpio_model) begin
            err_cnt++;
            $display("ERR gpio_o got=%h exp=%h", gpio_out_i, gpio_model);
         end
         if (iob_rvalid_i) begin
            rvalid_cnt++;
            if (!pend) begin
               err_cnt++;
               $display("Read valid at %0t without a read completing before it", $time);
            end else begin
               chk_cnt++;
               if (iob_rdata_i !== exp_rdata) begin
                  err_cnt++;
                  $display("ERR iob_rdata_o addr=%h got=%h exp=%h",
                           exp_addr, iob_rdata_i, exp_rdata);
               end
            end
         end else if (pend) begin
            err_cnt++;
            $display("Read of address %h got no read valid one cycle after ready", exp_addr);
         end
         pend = 1'b0;
         if (iob_valid_i && !valid_q) req_cnt++;
         valid_q = iob_valid_i;
         if (iob_ready_i) begin
            ready_cnt++;
            if (!iob_valid_i) begin
               err_cnt++;
               $display("Ready at %0t without a pending request", $time);
            end
            if (iob_wstrb_i == '0) begin
               pend      = 1'b1;
               exp_addr  = iob_addr_i;
               exp_rdata = ref_read(iob_addr_i);
               read_cnt++;
            end else if (!iob_addr_i[SLV_SEL_BIT]) begin
               rf_model[iob_addr_i[4:2]] =
                  merge_bytes(rf_model[iob_addr_i[4:2]], iob_wdata_i, iob_wstrb_i);
            end else if (iob_addr_i[2] == GPIO_OUT_OFS[2]) begin
               gpio_model = merge_bytes(gpio_model, iob_wdata_i, iob_wstrb_i);
            end
         end
         // Totals once the stimulus is done
         if (end_i && !end_seen) begin
            end_seen = 1'b1;
            if (req_cnt != issued_i || ready_cnt != req_cnt) begin
               err_cnt++;
               $display("Request count mismatch: %0d sent, %0d seen, %0d ready pulses",
                        issued_i, req_cnt, ready_cnt);
            end
            if (rvalid_cnt != read_cnt) begin
               err_cnt++;
               $display("%0d reads completed but %0d read valid pulses seen",
                        read_cnt, rvalid_cnt);
            end
         end
      end
   end

   assign err_cnt_o = err_cnt;
   assign chk_cnt_o = chk_cnt;

endmodule

`default_nettype wire

// File: bench/iob_apb_sys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module iob_apb_sys_tb
   import apb_pkg::*;
();

   localparam int        N_RANDOM    = 200;
   localparam int        N_DIRECTED  = RF_DEPTH + 1;
   localparam int        TIMEOUT_CYC = (N_DIRECTED + N_RANDOM) * 10 + 100;
   localparam apb_addr_t GPIO_BASE   = apb_addr_t'(1 << SLV_SEL_BIT);

   logic        clk;
   logic        rst_n;
   logic        iob_valid;
   apb_addr_t   iob_addr;
   apb_data_t   iob_wdata;
   apb_strb_t   iob_wstrb;
   logic        iob_ready;
   apb_data_t   iob_rdata;
   logic        iob_rvalid;
   apb_data_t   gpio_in;
   apb_data_t   gpio_out;
   logic        end_of_test;
   int          issued;
   int          err_cnt;
   int          chk_cnt;
   int          asrt_fails;
   int          cyc;
   logic [31:0] rnd;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   clk_gen clk_gen_i (
      .clk_o  (clk),
      .rst_n_o(rst_n)
   );

   iob_apb_sys dut_i (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .iob_valid_i (iob_valid),
      .iob_addr_i  (iob_addr),
      .iob_wdata_i (iob_wdata),
      .iob_wstrb_i (iob_wstrb),
      .iob_ready_o (iob_ready),
      .iob_rdata_o (iob_rdata),
      .iob_rvalid_o(iob_rvalid),
      .gpio_i      (gpio_in),
      .gpio_o      (gpio_out)
   );

   iob_apb_sys_checker chk_i (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .iob_valid_i (iob_valid),
      .iob_addr_i  (iob_addr),
      .iob_wdata_i (iob_wdata),
      .iob_wstrb_i (iob_wstrb),
      .iob_ready_i (iob_ready),
      .iob_rdata_i (iob_rdata),
      .iob_rvalid_i(iob_rvalid),
      .gpio_i      (gpio_in),
      .gpio_out_i  (gpio_out),
      .end_i       (end_of_test),
      .issued_i    (issued),
      .err_cnt_o   (err_cnt),
      .chk_cnt_o   (chk_cnt)
   );

   // One request, held until ready, valid dropped the cycle after
   task automatic do_request(input apb_addr_t addr, input apb_data_t wdata,
                             input apb_strb_t strb);
      @(negedge clk);
      iob_valid = 1'b1;
      iob_addr  = addr;
      iob_wdata = wdata;
      iob_wstrb = strb;
      do begin
         @(negedge clk);
      end while (!iob_ready);
      @(negedge clk);
      iob_valid = 1'b0;
      issued++;
   endtask

   task automatic run_random();
      apb_addr_t   addr;
      apb_strb_t   strb;
      logic [31:0] r;
      for (int n = 0; n < N_RANDOM; n++) begin
         rnd = lcg_next(rnd);
         r   = rnd;
         if (r[7:5] == 3'd0) begin  // Occasional input change, then settle
            rnd     = lcg_next(rnd);
            gpio_in = rnd;
            repeat (4) @(negedge clk);
         end
         case (r[31:30])
            2'd2:    addr = GPIO_BASE | GPIO_OUT_OFS;
            2'd3:    addr = GPIO_BASE | GPIO_IN_OFS;
            default: addr = {1'b0, r[21:16], r[28:26], 2'b00};
         endcase
         strb = r[9] ? 4'h0 : r[3:0];
         rnd  = lcg_next(rnd);
         do_request(addr, rnd, strb);
      end
   endtask

   initial begin
      cyc = 0;
      while (cyc < TIMEOUT_CYC) begin
         @(posedge clk);
         cyc++;
      end
      $display("Timeout after %0d cycles with %0d requests done", cyc, issued);
      $display("TB FAILED");
      $finish;
   end

   initial begin
      iob_valid   = 1'b0;
      iob_addr    = '0;
      iob_wdata   = '0;
      iob_wstrb   = '0;
      gpio_in     = '0;
      end_of_test = 1'b0;
      issued      = 0;
      rnd         = 32'h522ea974;
      wait (rst_n === 1'b1);
      // Reset values of every word and the output register
      for (int i = 0; i < RF_DEPTH; i++) begin
         do_request(apb_addr_t'(i * 4), '0, '0);
      end
      do_request(GPIO_BASE | GPIO_OUT_OFS, '0, '0);
      run_random();
      repeat (3) @(negedge clk);
      end_of_test = 1'b1;
      repeat (2) @(negedge clk);
      asrt_fails = dut_i.bridge_i.assert_i.fail_cnt;
      $display("Requests: %0d  checks: %0d  errors: %0d  assertion failures: %0d",
               issued, chk_cnt, err_cnt, asrt_fails);
      if (err_cnt == 0 && asrt_fails == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
hdl/apb_pkg.sv
hdl/apb_if.sv
hdl/iob2apb.sv
hdl/apb_decoder.sv
hdl/apb_regfile.sv
hdl/apb_gpio.sv
hdl/iob_apb_sys.sv
bench/clk_gen.sv
bench/iob_apb_sys_assert.sv
bench/iob_apb_sys_checker.sv
bench/iob_apb_sys_tb.sv
